/* hw/lpif_auto_sync.sv */
`timescale 1ns/100ps
`default_nettype none

module lpif_auto_sync (
  input  logic       clk_wr,
  input  logic       arst_n,

  input  logic       tx_online,
  input  logic       rx_online,
  input  logic [7:0] delay_x_value,
  input  logic [7:0] delay_xz_value,

  output logic       tx_online_delay,
  output logic       rx_online_delay,
  output logic       tx_mrk_userbit,
  output logic       tx_stb_userbit
);

  //////////////////////////////////////////////////////////////////////
  // Per-direction delay channels
  // Index 0 is TX, index 1 is RX

  logic [1:0]      online_in;
  logic [1:0][7:0] delay_val;
  logic [1:0]      online_q;
  logic [1:0][7:0] delay_cnt;
  logic [1:0]      online_dly;

  assign online_in[0] = tx_online;
  assign online_in[1] = rx_online;
  assign delay_val[0] = delay_xz_value;
  assign delay_val[1] = delay_x_value;

  for (genvar i = 0; i < 2; i++) begin : g_chan

    // Edge detect on the raw online input
    always_ff @(posedge clk_wr or negedge arst_n) begin
      if (!arst_n) begin
        online_q[i] <= 1'b0;
      end else begin
        online_q[i] <= online_in[i];
      end
    end

    // Saturating down-counter, loaded on the rising edge
    always_ff @(posedge clk_wr or negedge arst_n) begin
      if (!arst_n) begin
        delay_cnt[i] <= 8'd0;
      end else if (!online_in[i]) begin
        delay_cnt[i] <= 8'd0;
      end else if (!online_q[i]) begin
        delay_cnt[i] <= delay_val[i];
      end else if (delay_cnt[i] != 8'd0) begin
        delay_cnt[i] <= delay_cnt[i] - 8'd1;
      end
    end

    // Sets once the count has run out, drops right after the input
    always_ff @(posedge clk_wr or negedge arst_n) begin
      if (!arst_n) begin
        online_dly[i] <= 1'b0;
      end else if (!online_in[i]) begin
        online_dly[i] <= 1'b0;
      end else if (online_q[i] && (delay_cnt[i] == 8'd0)) begin
        online_dly[i] <= 1'b1;
      end
    end

  end

  assign tx_online_delay = online_dly[0];
  assign rx_online_delay = online_dly[1];

  //////////////////////////////////////////////////////////////////////
  // User bits
  // Persistent marker and strobe, held high for as long as TX is up

  assign tx_mrk_userbit = online_dly[0];
  assign tx_stb_userbit = online_dly[0];

endmodule

`default_nettype wire

/* hw/lpif_flit_pack.sv */
`timescale 1ns/100ps
`default_nettype none

module lpif_flit_pack
  import lpif_link_pkg::*;
#(
  parameter int DATA_W    = DEF_DATA_W,
  parameter int NUM_LANES = DEF_NUM_LANES
) (
  input  logic                                  clk_wr,
  input  logic                                  arst_n,

  // Downstream flit
  input  lpif_state_e                           dstrm_state,
  input  lpif_protid_e                          dstrm_protid,
  input  logic [DATA_W-1:0]                     dstrm_data,
  input  logic [bstart_w(DATA_W)-1:0]           dstrm_bstart,
  input  logic [DATA_W/8-1:0]                   dstrm_bvalid,
  input  logic                                  dstrm_valid,

  // Upstream flit
  output lpif_state_e                           ustrm_state,
  output lpif_protid_e                          ustrm_protid,
  output logic [DATA_W-1:0]                     ustrm_data,
  output logic [bstart_w(DATA_W)-1:0]           ustrm_bstart,
  output logic [DATA_W/8-1:0]                   ustrm_bvalid,
  output logic                                  ustrm_valid,

  // Packed words to and from the striper
  output logic [NUM_LANES*LANE_PAYLOAD_W-1:0]   tx_flit_word,
  input  logic [NUM_LANES*LANE_PAYLOAD_W-1:0]   rx_flit_word,
  input  logic                                  rx_frame_ok
);

  localparam int BYTES     = DATA_W / 8;
  localparam int BSTART_W  = bstart_w(DATA_W);
  localparam int FLIT_W    = flit_w(DATA_W);
  localparam int WORD_W    = NUM_LANES * LANE_PAYLOAD_W;
  localparam int BSTART_LO = FLIT_VALID_BIT + 1;
  localparam int BVALID_LO = BSTART_LO + BSTART_W;
  localparam int DATA_LO   = BVALID_LO + BYTES;
  localparam int PROTID_LO = DATA_LO + DATA_W;
  localparam int STATE_LO  = PROTID_LO + PROTID_W;

  //////////////////////////////////////////////////////////////////////
  // TX pack

  logic                tx_valid_q;
  logic [FLIT_W-2:0]   tx_fields_q;

  always_ff @(posedge clk_wr or negedge arst_n) begin
    if (!arst_n) begin
      tx_valid_q <= 1'b0;
    end else begin
      tx_valid_q <= dstrm_valid;
    end
  end

  // Everything above the valid bit, in layout order
  always_ff @(posedge clk_wr) begin
    tx_fields_q <= {dstrm_state, dstrm_protid, dstrm_data, dstrm_bvalid, dstrm_bstart};
  end

  // Unused payload above the flit goes out as zero
  assign tx_flit_word = {{(WORD_W - FLIT_W){1'b0}}, tx_fields_q, tx_valid_q};

  //////////////////////////////////////////////////////////////////////
  // RX unpack

  always_ff @(posedge clk_wr or negedge arst_n) begin
    if (!arst_n) begin
      ustrm_valid <= 1'b0;
    end else begin
      ustrm_valid <= rx_frame_ok & rx_flit_word[FLIT_VALID_BIT];
    end
  end

  always_ff @(posedge clk_wr) begin
    ustrm_state  <= lpif_state_e'(rx_flit_word[STATE_LO +: STATE_W]);
    ustrm_protid <= lpif_protid_e'(rx_flit_word[PROTID_LO +: PROTID_W]);
    ustrm_data   <= rx_flit_word[DATA_LO +: DATA_W];
    ustrm_bvalid <= rx_flit_word[BVALID_LO +: BYTES];
    ustrm_bstart <= rx_flit_word[BSTART_LO +: BSTART_W];
  end

endmodule

`default_nettype wire

/* hw/lpif_lane_striper.sv */
`timescale 1ns/100ps
`default_nettype none

module lpif_lane_striper
  import lpif_link_pkg::*;
#(
  parameter int NUM_LANES = DEF_NUM_LANES
) (
  input  logic                                  clk_wr,
  input  logic                                  arst_n,

  // Flit side
  input  logic [NUM_LANES*LANE_PAYLOAD_W-1:0]   tx_flit_word,
  output logic [NUM_LANES*LANE_PAYLOAD_W-1:0]   rx_flit_word,
  output logic                                  rx_frame_ok,

  // Link control
  input  logic                                  tx_online_delay,
  input  logic                                  rx_online_delay,
  input  logic                                  tx_mrk_userbit,
  input  logic                                  tx_stb_userbit,

  // PHY lanes
  output logic [NUM_LANES*LANE_W-1:0]           tx_phy,
  input  logic [NUM_LANES*LANE_W-1:0]           rx_phy,

  // Debug
  output logic [31:0]                           tx_debug_status,
  output logic [31:0]                           rx_debug_status
);

  logic [NUM_LANES-1:0][LANE_PAYLOAD_W-1:0] tx_chunk;
  logic [NUM_LANES-1:0][LANE_W-1:0]         tx_lane;
  logic [NUM_LANES-1:0][LANE_W-1:0]         rx_lane;
  logic [NUM_LANES-1:0][LANE_PAYLOAD_W-1:0] rx_chunk;
  logic [NUM_LANES-1:0]                     lane_ok;
  logic                                     frame_good;

  //////////////////////////////////////////////////////////////////////
  // TX framing

  assign tx_chunk = tx_flit_word;

  for (genvar i = 0; i < NUM_LANES; i++) begin : g_tx_lane
    // Marker on top, strobe between the low payload bit and the rest
    assign tx_lane[i] = {tx_mrk_userbit,
                         tx_chunk[i][LANE_PAYLOAD_W-1:STB_BIT],
                         tx_stb_userbit,
                         tx_chunk[i][STB_BIT-1:0]};
  end

  // Lanes stay quiet until TX is up
  always_ff @(posedge clk_wr or negedge arst_n) begin
    if (!arst_n) begin
      tx_phy <= '0;
    end else if (tx_online_delay) begin
      tx_phy <= tx_lane;
    end else begin
      tx_phy <= '0;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // RX framing check

  assign rx_lane = rx_phy;

  for (genvar i = 0; i < NUM_LANES; i++) begin : g_rx_lane
    assign rx_chunk[i] = {rx_lane[i][MRK_BIT-1:STB_BIT+1], rx_lane[i][STB_BIT-1:0]};
    assign lane_ok[i]  = rx_lane[i][MRK_BIT] & rx_lane[i][STB_BIT];
  end

  assign frame_good = &lane_ok;

  always_ff @(posedge clk_wr) begin
    rx_flit_word <= rx_chunk;
  end

  always_ff @(posedge clk_wr or negedge arst_n) begin
    if (!arst_n) begin
      rx_frame_ok <= 1'b0;
    end else begin
      rx_frame_ok <= rx_online_delay & frame_good;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Debug counters, all wrapping

  logic [31:0] tx_sent_cnt;
  logic [15:0] rx_ok_cnt;
  logic [15:0] rx_bad_cnt;

  // Flits launched onto the lanes
  always_ff @(posedge clk_wr or negedge arst_n) begin
    if (!arst_n) begin
      tx_sent_cnt <= 32'd0;
    end else if (tx_online_delay && tx_flit_word[FLIT_VALID_BIT]) begin
      tx_sent_cnt <= tx_sent_cnt + 32'd1;
    end
  end

  // Accepted flits line up with ustrm_valid
  always_ff @(posedge clk_wr or negedge arst_n) begin
    if (!arst_n) begin
      rx_ok_cnt <= 16'd0;
    end else if (rx_frame_ok && rx_flit_word[FLIT_VALID_BIT]) begin
      rx_ok_cnt <= rx_ok_cnt + 16'd1;
    end
  end

  // RX online but marker or strobe missing
  always_ff @(posedge clk_wr or negedge arst_n) begin
    if (!arst_n) begin
      rx_bad_cnt <= 16'd0;
    end else if (rx_online_delay && !frame_good) begin
      rx_bad_cnt <= rx_bad_cnt + 16'd1;
    end
  end

  assign tx_debug_status = tx_sent_cnt;
  assign rx_debug_status = {rx_bad_cnt, rx_ok_cnt};

endmodule

`default_nettype wire

/* hw/lpif_link_pkg.sv */
`default_nettype none

package lpif_link_pkg;

  // PHY lane word framing
  localparam int LANE_W         = 40;
  localparam int LANE_PAYLOAD_W = 38;
  localparam int MRK_BIT        = 39;
  localparam int STB_BIT        = 1;

  // Defaults handed down from the top level
  localparam int DEF_DATA_W    = 64;
  localparam int DEF_NUM_LANES = 4;

  // Flit layout, bit 0 upward: valid, bstart, bvalid, data, protid, state
  localparam int FLIT_VALID_BIT = 0;
  localparam int PROTID_W       = 2;
  localparam int STATE_W        = 4;

  // LPIF link state encodings
  typedef enum logic [STATE_W-1:0] {
    RESET     = 4'b0000,
    ACTIVE    = 4'b0001,
    L1        = 4'b0100,
    LINKERROR = 4'b1010,
    RETRAIN   = 4'b1011
  } lpif_state_e;

  typedef enum logic [PROTID_W-1:0] {
    PROT_IO     = 2'd0,
    PROT_CACHE  = 2'd1,
    PROT_MEM    = 2'd2,
    PROT_STREAM = 2'd3
  } lpif_protid_e;

  // Width of the byte start field for a given data width
  function automatic int bstart_w(input int data_w);
    return $clog2(data_w / 8);
  endfunction

  // Total packed flit width
  function automatic int flit_w(input int data_w);
    return 1 + bstart_w(data_w) + data_w / 8 + data_w + PROTID_W + STATE_W;
  endfunction

endpackage

`default_nettype wire

/* hw/lpif_link_top.sv */
`timescale 1ns/100ps
`default_nettype none

module lpif_link_top
  import lpif_link_pkg::*;
#(
  parameter int DATA_W    = DEF_DATA_W,
  parameter int NUM_LANES = DEF_NUM_LANES
) (
  input  logic                             clk_wr,
  input  logic                             arst_n,

  // Control
  input  logic                             tx_online,
  input  logic                             rx_online,
  input  logic [7:0]                       delay_x_value,
  input  logic [7:0]                       delay_xz_value,

  // PHY lanes
  output logic [NUM_LANES*LANE_W-1:0]      tx_phy,
  input  logic [NUM_LANES*LANE_W-1:0]      rx_phy,

  // Downstream channel
  input  lpif_state_e                      dstrm_state,
  input  lpif_protid_e                     dstrm_protid,
  input  logic [DATA_W-1:0]                dstrm_data,
  input  logic [bstart_w(DATA_W)-1:0]      dstrm_bstart,
  input  logic [DATA_W/8-1:0]              dstrm_bvalid,
  input  logic                             dstrm_valid,

  // Upstream channel
  output lpif_state_e                      ustrm_state,
  output lpif_protid_e                     ustrm_protid,
  output logic [DATA_W-1:0]                ustrm_data,
  output logic [bstart_w(DATA_W)-1:0]      ustrm_bstart,
  output logic [DATA_W/8-1:0]              ustrm_bvalid,
  output logic                             ustrm_valid,

  // Debug status
  output logic [31:0]                      tx_debug_status,
  output logic [31:0]                      rx_debug_status
);

  //////////////////////////////////////////////////////////////////////
  // Interconnect

  logic                                tx_online_delay;
  logic                                rx_online_delay;
  logic                                tx_mrk_userbit;
  logic                                tx_stb_userbit;
  logic [NUM_LANES*LANE_PAYLOAD_W-1:0] tx_flit_word;
  logic [NUM_LANES*LANE_PAYLOAD_W-1:0] rx_flit_word;
  logic                                rx_frame_ok;

  //////////////////////////////////////////////////////////////////////
  // Online sequencing

  lpif_auto_sync u_auto_sync (
    .clk_wr          (clk_wr),
    .arst_n          (arst_n),
    .tx_online       (tx_online),
    .rx_online       (rx_online),
    .delay_x_value   (delay_x_value),
    .delay_xz_value  (delay_xz_value),
    .tx_online_delay (tx_online_delay),
    .rx_online_delay (rx_online_delay),
    .tx_mrk_userbit  (tx_mrk_userbit),
    .tx_stb_userbit  (tx_stb_userbit)
  );

  //////////////////////////////////////////////////////////////////////
  // Flit pack and unpack

  lpif_flit_pack #(
    .DATA_W    (DATA_W),
    .NUM_LANES (NUM_LANES)
  ) u_flit_pack (
    .clk_wr       (clk_wr),
    .arst_n       (arst_n),
    .dstrm_state  (dstrm_state),
    .dstrm_protid (dstrm_protid),
    .dstrm_data   (dstrm_data),
    .dstrm_bstart (dstrm_bstart),
    .dstrm_bvalid (dstrm_bvalid),
    .dstrm_valid  (dstrm_valid),
    .ustrm_state  (ustrm_state),
    .ustrm_protid (ustrm_protid),
    .ustrm_data   (ustrm_data),
    .ustrm_bstart (ustrm_bstart),
    .ustrm_bvalid (ustrm_bvalid),
    .ustrm_valid  (ustrm_valid),
    .tx_flit_word (tx_flit_word),
    .rx_flit_word (rx_flit_word),
    .rx_frame_ok  (rx_frame_ok)
  );

  //////////////////////////////////////////////////////////////////////
  // Lane striping

  lpif_lane_striper #(
    .NUM_LANES (NUM_LANES)
  ) u_lane_striper (
    .clk_wr          (clk_wr),
    .arst_n          (arst_n),
    .tx_flit_word    (tx_flit_word),
    .rx_flit_word    (rx_flit_word),
    .rx_frame_ok     (rx_frame_ok),
    .tx_online_delay (tx_online_delay),
    .rx_online_delay (rx_online_delay),
    .tx_mrk_userbit  (tx_mrk_userbit),
    .tx_stb_userbit  (tx_stb_userbit),
    .tx_phy          (tx_phy),
    .rx_phy          (rx_phy),
    .tx_debug_status (tx_debug_status),
    .rx_debug_status (rx_debug_status)
  );

endmodule

`default_nettype wire

/* project.f */
hw/lpif_link_pkg.sv
hw/lpif_auto_sync.sv
hw/lpif_flit_pack.sv
hw/lpif_lane_striper.sv
hw/lpif_link_top.sv
tb/tb_lpif_link.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build and run the LPIF link testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --top-module tb_lpif_link -f project.f \
  --Mdir obj_dir -o tb_lpif_link
status=$?
if [ "$status" -ne 0 ]; then
  echo "Verilator build failed with status $status"
  exit 1
fi

./obj_dir/tb_lpif_link 2>&1 | tee sim.log
status=${PIPESTATUS[0]}
if [ "$status" -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -q ">>> FAIL" sim.log; then
  echo "Failure reported in sim.log"
  exit 1
fi

if ! grep -q ">>> PASS" sim.log; then
  echo "No pass line found in sim.log"
  exit 1
fi

echo "Simulation passed"
exit 0

/* tb/tb_lpif_link.sv */
`timescale 1ns/100ps
`default_nettype none

module tb_lpif_link
  import lpif_link_pkg::*;
();

  localparam int DATA_W       = DEF_DATA_W;
  localparam int NUM_LANES    = DEF_NUM_LANES;
  localparam int BYTES        = DATA_W / 8;
  localparam int BSTART_W     = bstart_w(DATA_W);
  localparam int PHY_W        = NUM_LANES * LANE_W;
  localparam int CLK_PERIOD   = 8;
  localparam int RESET_CYCLES = 8;
  localparam int N_LOOP       = 300;
  localparam int N_ERR        = 200;
  localparam int N_DRAIN      = 4;
  localparam int N_OFF        = 20;
  // Worst case online waits are 255+3 (TX) and 255+4 (RX) cycles
  localparam int TEST_CYCLES  = RESET_CYCLES + 2 + 258 + 259
                                + N_LOOP + N_ERR + N_DRAIN + N_OFF;
  localparam int WATCHDOG_NS  = TEST_CYCLES * CLK_PERIOD * 2;

  logic                clk_wr = 1'b0;
  logic                arst_n;
  logic                tx_online;
  logic                rx_online;
  logic [7:0]          delay_x_value;
  logic [7:0]          delay_xz_value;
  logic [PHY_W-1:0]    tx_phy;
  logic [PHY_W-1:0]    rx_phy;
  logic [PHY_W-1:0]    corrupt_mask;
  lpif_state_e         dstrm_state;
  lpif_protid_e        dstrm_protid;
  logic [DATA_W-1:0]   dstrm_data;
  logic [BSTART_W-1:0] dstrm_bstart;
  logic [BYTES-1:0]    dstrm_bvalid;
  logic                dstrm_valid;
  lpif_state_e         ustrm_state;
  lpif_protid_e        ustrm_protid;
  logic [DATA_W-1:0]   ustrm_data;
  logic [BSTART_W-1:0] ustrm_bstart;
  logic [BYTES-1:0]    ustrm_bvalid;
  logic                ustrm_valid;
  logic [31:0]         tx_debug_status;
  logic [31:0]         rx_debug_status;

  // Reference model state
  logic [31:0]         seed;
  lpif_state_e         q_state[$];
  lpif_protid_e        q_protid[$];
  logic [DATA_W-1:0]   q_data[$];
  logic [BSTART_W-1:0] q_bstart[$];
  logic [BYTES-1:0]    q_bvalid[$];
  logic                q_valid[$];
  logic [1:0]          bad_hist;
  logic [31:0]         model_tx;
  logic [15:0]         model_ok;
  logic [15:0]         model_bad;

  always #(CLK_PERIOD / 2) clk_wr = ~clk_wr;

  // Lanes looped back, with marker flips injected on the way
  assign rx_phy = tx_phy ^ corrupt_mask;

  lpif_link_top #(
    .DATA_W    (DATA_W),
    .NUM_LANES (NUM_LANES)
  ) UUT (
    .clk_wr          (clk_wr),
    .arst_n          (arst_n),
    .tx_online       (tx_online),
    .rx_online       (rx_online),
    .delay_x_value   (delay_x_value),
    .delay_xz_value  (delay_xz_value),
    .tx_phy          (tx_phy),
    .rx_phy          (rx_phy),
    .dstrm_state     (dstrm_state),
    .dstrm_protid    (dstrm_protid),
    .dstrm_data      (dstrm_data),
    .dstrm_bstart    (dstrm_bstart),
    .dstrm_bvalid    (dstrm_bvalid),
    .dstrm_valid     (dstrm_valid),
    .ustrm_state     (ustrm_state),
    .ustrm_protid    (ustrm_protid),
    .ustrm_data      (ustrm_data),
    .ustrm_bstart    (ustrm_bstart),
    .ustrm_bvalid    (ustrm_bvalid),
    .ustrm_valid     (ustrm_valid),
    .tx_debug_status (tx_debug_status),
    .rx_debug_status (rx_debug_status)
  );

  ////////////////////////////////////////////////////////////////////
  // Compare tasks

  task automatic report_mismatch(input string msg);
    $display("MISMATCH at %0t ns: %s", $time, msg);
    $display(">>> FAIL");
    $fatal(1, "Stopped at first mismatch");
  endtask

  task automatic check_flit(
    input string               what,
    input lpif_state_e         got_state,
    input lpif_protid_e        got_protid,
    input logic [DATA_W-1:0]   got_data,
    input logic [BSTART_W-1:0] got_bstart,
    input logic [BYTES-1:0]    got_bvalid,
    input logic                got_valid,
    input lpif_state_e         exp_state,
    input lpif_protid_e        exp_protid,
    input logic [DATA_W-1:0]   exp_data,
    input logic [BSTART_W-1:0] exp_bstart,
    input logic [BYTES-1:0]    exp_bvalid,
    input logic                exp_valid
  );
    if (got_valid !== exp_valid) begin
      report_mismatch($sformatf("%s valid got %b expected %b", what, got_valid, exp_valid));
    end
    if (got_state !== exp_state) begin
      report_mismatch($sformatf("%s state got %h expected %h", what, got_state, exp_state));
    end
    if (got_protid !== exp_protid) begin
      report_mismatch($sformatf("%s protid got %h expected %h", what, got_protid, exp_protid));
    end
    if (got_data !== exp_data) begin
      report_mismatch($sformatf("%s data got %h expected %h", what, got_data, exp_data));
    end
    if (got_bstart !== exp_bstart) begin
      report_mismatch($sformatf("%s bstart got %h expected %h", what, got_bstart, exp_bstart));
    end
    if (got_bvalid !== exp_bvalid) begin
      report_mismatch($sformatf("%s bvalid got %h expected %h", what, got_bvalid, exp_bvalid));
    end
  endtask

  task automatic check_status(input string what, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      report_mismatch($sformatf("%s got %h expected %h", what, got, exp));
    end
  endtask

  task automatic check_lanes(input string what, input logic [PHY_W-1:0] got,
                             input logic [PHY_W-1:0] exp);
    if (got !== exp) begin
      report_mismatch($sformatf("%s got %h expected %h", what, got, exp));
    end
  endtask

  ////////////////////////////////////////////////////////////////////
  // Model helpers

  // Lanes carrying an all-zero payload, only marker and strobe set
  function automatic logic [PHY_W-1:0] idle_frame();
    logic [PHY_W-1:0] v;
    v = '0;
    for (int l = 0; l < NUM_LANES; l++) begin
      v[l*LANE_W + MRK_BIT] = 1'b1;
      v[l*LANE_W + STB_BIT] = 1'b1;
    end
    return v;
  endfunction

  function automatic lpif_state_e pick_state(input logic [2:0] sel);
    case (sel)
      3'd0:    return RESET;
      3'd1:    return ACTIVE;
      3'd2:    return L1;
      3'd3:    return RETRAIN;
      default: return LINKERROR;
    endcase
  endfunction

  task automatic queue_flit(input lpif_state_e st, input lpif_protid_e pid,
                            input logic [DATA_W-1:0] data, input logic [BSTART_W-1:0] bs,
                            input logic [BYTES-1:0] bv, input logic vld);
    q_state.push_back(st);
    q_protid.push_back(pid);
    q_data.push_back(data);
    q_bstart.push_back(bs);
    q_bvalid.push_back(bv);
    q_valid.push_back(vld);
  endtask

  // One cycle per step: check the flit sent 4 steps back, then drive the next
  task automatic run_steps(input int n, input bit active, input bit corrupt);
    logic [31:0]         rnd;
    logic [31:0]         rnd_hi;
    logic [31:0]         rnd_lo;
    logic                exp_valid;
    logic                bad_now;
    int                  lane;
    lpif_state_e         d_state;
    lpif_protid_e        d_protid;
    logic [DATA_W-1:0]   d_data;
    logic [BSTART_W-1:0] d_bstart;
    logic [BYTES-1:0]    d_bvalid;
    logic                d_valid;
    for (int s = 0; s < n; s++) begin
      @(posedge clk_wr);
      #1;
      // A marker flip two steps ago hit the flit now at the output
      exp_valid = q_valid.pop_front() & ~bad_hist[1];
      check_flit("ustrm", ustrm_state, ustrm_protid, ustrm_data, ustrm_bstart, ustrm_bvalid,
                 ustrm_valid, q_state.pop_front(), q_protid.pop_front(), q_data.pop_front(),
                 q_bstart.pop_front(), q_bvalid.pop_front(), exp_valid);
      if (exp_valid) begin
        model_ok = model_ok + 16'd1;
      end
      if (active) begin
        rnd      = $random(seed);
        rnd_hi   = $random(seed);
        rnd_lo   = $random(seed);
        d_state  = pick_state(rnd[2:0]);
        d_protid = lpif_protid_e'(rnd[4:3]);
        d_bstart = rnd[5 +: BSTART_W];
        d_bvalid = rnd[8 +: BYTES];
        d_valid  = rnd[16];
        d_data   = {rnd_hi, rnd_lo};
      end else begin
        d_state  = RESET;
        d_protid = PROT_IO;
        d_bstart = '0;
        d_bvalid = '0;
        d_valid  = 1'b0;
        d_data   = '0;
      end
      bad_now      = 1'b0;
      corrupt_mask = '0;
      if (corrupt) begin
        rnd = $random(seed);
        if (rnd[1:0] == 2'b00) begin
          lane = (rnd >> 2) % NUM_LANES;
          corrupt_mask[lane*LANE_W + MRK_BIT] = 1'b1;
          bad_now   = 1'b1;
          model_bad = model_bad + 16'd1;
        end
      end
      bad_hist = {bad_hist[0], bad_now};
      if (d_valid) begin
        model_tx = model_tx + 32'd1;
      end
      queue_flit(d_state, d_protid, d_data, d_bstart, d_bvalid, d_valid);
      dstrm_state  = d_state;
      dstrm_protid = d_protid;
      dstrm_data   = d_data;
      dstrm_bstart = d_bstart;
      dstrm_bvalid = d_bvalid;
      dstrm_valid  = d_valid;
    end
  endtask

  ////////////////////////////////////////////////////////////////////
  // Main sequence

  initial begin
    logic [31:0] rnd;
    seed           = 32'h1017_e21e;
    arst_n         = 1'b0;
    tx_online      = 1'b0;
    rx_online      = 1'b0;
    delay_x_value  = 8'd0;
    delay_xz_value = 8'd0;
    corrupt_mask   = '0;
    dstrm_state    = RESET;
    dstrm_protid   = PROT_IO;
    dstrm_data     = '0;
    dstrm_bstart   = '0;
    dstrm_bvalid   = '0;
    dstrm_valid    = 1'b0;
    bad_hist       = 2'b00;
    model_tx       = 32'd0;
    model_ok       = 16'd0;
    model_bad      = 16'd0;
    repeat (RESET_CYCLES) @(posedge clk_wr);
    #1;
    arst_n = 1'b1;
    repeat (2) @(posedge clk_wr);
    #1;

    // Reset state, both sides offline
    check_lanes("tx_phy after reset", tx_phy, '0);
    check_flit("ustrm after reset", ustrm_state, ustrm_protid, ustrm_data, ustrm_bstart,
               ustrm_bvalid, ustrm_valid, RESET, PROT_IO, '0, '0, '0, 1'b0);
    check_status("tx_debug_status after reset", tx_debug_status, 32'd0);
    check_status("rx_debug_status after reset", rx_debug_status, 32'd0);

    // TX online delay
    rnd            = $random(seed);
    delay_xz_value = rnd[7:0];
    delay_x_value  = rnd[15:8];
    tx_online      = 1'b1;
    repeat (32'(delay_xz_value) + 2) begin
      @(posedge clk_wr);
      #1;
      check_lanes("tx_phy during online delay", tx_phy, '0);
    end
    @(posedge clk_wr);
    #1;
    check_lanes("tx_phy once online", tx_phy, idle_frame());

    // RX comes up behind TX so no bad frames are seen
    rx_online = 1'b1;
    repeat (32'(delay_x_value) + 4) @(posedge clk_wr);
    #1;
    check_status("rx_debug_status after RX online", rx_debug_status, 32'd0);

    // Pipeline holds idle flits before the first random one
    repeat (4) queue_flit(RESET, PROT_IO, '0, '0, '0, 1'b0);
    run_steps(N_LOOP, 1'b1, 1'b0);
    run_steps(N_ERR, 1'b1, 1'b1);
    run_steps(N_DRAIN, 1'b0, 1'b0);
    check_status("tx_debug_status", tx_debug_status, model_tx);
    check_status("rx_debug_status", rx_debug_status, {model_bad, model_ok});

    // Going offline, every flit from here on is dropped
    tx_online = 1'b0;
    for (int k = 1; k <= N_OFF; k++) begin
      @(posedge clk_wr);
      #1;
      check_flit("ustrm while offline", ustrm_state, ustrm_protid, ustrm_data, ustrm_bstart,
                 ustrm_bvalid, ustrm_valid, RESET, PROT_IO, '0, '0, '0, 1'b0);
      if (k >= 2) begin
        check_lanes("tx_phy while offline", tx_phy, '0);
      end
      rnd          = $random(seed);
      dstrm_valid  = rnd[0];
      dstrm_state  = pick_state(rnd[3:1]);
      dstrm_bvalid = rnd[8 +: BYTES];
    end
    // Zero lanes from the second step on, each counted a cycle later
    model_bad = model_bad + 16'(N_OFF - 2);
    check_status("tx_debug_status offline", tx_debug_status, model_tx);
    check_status("rx_debug_status offline", rx_debug_status, {model_bad, model_ok});

    $display(">>> PASS");
    $finish;
  end

  // Watchdog
  initial begin
    #(WATCHDOG_NS);
    $display("Timeout: the test did not finish within %0d ns", WATCHDOG_NS);
    $display(">>> FAIL");
    $fatal(1, "Watchdog expired");
  end

endmodule

`default_nettype wire
